// File: rtl/decode_pkg.sv
/*
 * decode stage shared definitions
 * widths, no-op values and control field encodings for RV32I decode
 */
`default_nettype none

package decode_pkg;

    localparam int xlen       = 32;
    localparam int reg_addr_w = 5;

    localparam logic [xlen-1:0] inst_nop    = 32'h0000_0013; // addi x0, x0, 0
    localparam logic [xlen-1:0] regpc_nop   = '0;
    localparam logic [xlen-1:0] poison_data = '1;

    typedef enum logic [4:0] {
        alu_add, alu_sub, alu_and, alu_or, alu_xor,
        alu_sll, alu_srl, alu_sra, alu_slt, alu_sltu, alu_jalr,
        br_beq, br_bne, br_blt, br_bge, br_bltu, br_bgeu
    } alu_fun_e;

    typedef enum logic [1:0] {op1_rs1, op1_pc, op1_none} op1_sel_e;

    typedef enum logic [2:0] {
        op2_rs2, op2_imm_i, op2_imm_s, op2_imm_j, op2_imm_u, op2_none
    } op2_sel_e;

    typedef enum logic [3:0] {
        mem_none, mem_lb, mem_lbu, mem_lh, mem_lhu, mem_lw, mem_sb, mem_sh, mem_sw
    } mem_fun_e;

    typedef enum logic [2:0] {
        wb_none, wb_alu, wb_pc, wb_mem_b, wb_mem_bu, wb_mem_h, wb_mem_hu, wb_mem_w
    } wb_sel_e;

    // major opcodes
    localparam logic [6:0] opc_load   = 7'b0000011;
    localparam logic [6:0] opc_store  = 7'b0100011;
    localparam logic [6:0] opc_op_imm = 7'b0010011;
    localparam logic [6:0] opc_op     = 7'b0110011;
    localparam logic [6:0] opc_branch = 7'b1100011;
    localparam logic [6:0] opc_jal    = 7'b1101111;
    localparam logic [6:0] opc_jalr   = 7'b1100111;
    localparam logic [6:0] opc_lui    = 7'b0110111;
    localparam logic [6:0] opc_auipc  = 7'b0010111;

    // load / store widths
    localparam logic [2:0] f3_b  = 3'b000;
    localparam logic [2:0] f3_h  = 3'b001;
    localparam logic [2:0] f3_w  = 3'b010;
    localparam logic [2:0] f3_bu = 3'b100;
    localparam logic [2:0] f3_hu = 3'b101;

    // alu ops, shared by reg and imm forms
    localparam logic [2:0] f3_add  = 3'b000;
    localparam logic [2:0] f3_sll  = 3'b001;
    localparam logic [2:0] f3_slt  = 3'b010;
    localparam logic [2:0] f3_sltu = 3'b011;
    localparam logic [2:0] f3_xor  = 3'b100;
    localparam logic [2:0] f3_sr   = 3'b101; // srl or sra by funct7
    localparam logic [2:0] f3_or   = 3'b110;
    localparam logic [2:0] f3_and  = 3'b111;

    localparam logic [2:0] f3_beq  = 3'b000;
    localparam logic [2:0] f3_bne  = 3'b001;
    localparam logic [2:0] f3_blt  = 3'b100;
    localparam logic [2:0] f3_bge  = 3'b101;
    localparam logic [2:0] f3_bltu = 3'b110;
    localparam logic [2:0] f3_bgeu = 3'b111;
    localparam logic [2:0] f3_jalr = 3'b000;

    localparam logic [6:0] f7_base = 7'b0000000;
    localparam logic [6:0] f7_alt  = 7'b0100000; // sub, sra, srai

endpackage

`default_nettype wire

// File: rtl/inst_hold_buffer.sv
/*
 * instruction hold buffer
 * picks the instruction that decode works on and keeps a copy
 * of it while the stage is stalled, for replay afterwards
 */
`default_nettype none

module inst_hold_buffer (
    input  wire logic                        clk,
    input  wire logic                        arst_n,
    input  wire logic [decode_pkg::xlen-1:0] inst_in,
    input  wire logic [decode_pkg::xlen-1:0] pc_in,
    input  wire logic                        mem_stall,
    input  wire logic                        branch_flush,
    input  wire logic                        data_hazard_stall,
    output logic      [decode_pkg::xlen-1:0] inst,
    output logic      [decode_pkg::xlen-1:0] pc
);
    import decode_pkg::*;

    logic [xlen-1:0] saved_inst;
    logic [xlen-1:0] saved_pc;
    logic            last_hazard;
    logic            use_saved;

    assign use_saved = mem_stall || last_hazard;

    assign inst = branch_flush ? inst_nop  : (use_saved ? saved_inst : inst_in);
    assign pc   = branch_flush ? regpc_nop : (use_saved ? saved_pc : pc_in);

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            saved_inst  <= inst_nop;
            saved_pc    <= regpc_nop;
            last_hazard <= 1'b0;
        end else begin
            last_hazard <= data_hazard_stall;
            if (branch_flush) begin   // flushed slot replays as a no-op
                saved_inst <= inst_nop;
                saved_pc   <= regpc_nop;
            end else if (mem_stall || data_hazard_stall) begin
                saved_inst <= inst;
                saved_pc   <= pc;
            end
        end
    end

endmodule

`default_nettype wire

// File: rtl/hazard_detect.sv
/*
 * data hazard detection
 * stalls decode while a later stage still has to write a source register
 */
`default_nettype none

module hazard_detect (
    input  wire logic [decode_pkg::reg_addr_w-1:0] rs1_addr,
    input  wire logic [decode_pkg::reg_addr_w-1:0] rs2_addr,
    input  wire logic                              exe_rf_wen,
    input  wire logic                              mem_rf_wen,
    input  wire logic                              wb_rf_wen,
    input  wire logic [decode_pkg::reg_addr_w-1:0] exe_wb_addr,
    input  wire logic [decode_pkg::reg_addr_w-1:0] mem_wb_addr,
    input  wire logic [decode_pkg::reg_addr_w-1:0] wb_wb_addr,
    input  wire logic                              branch_flush,
    output logic                                   data_hazard_stall
);

    logic rs1_live;
    logic rs2_live;
    logic rs1_hit;
    logic rs2_hit;

    // x0 never creates a dependency
    assign rs1_live = (rs1_addr != '0);
    assign rs2_live = (rs2_addr != '0);

    assign rs1_hit = rs1_live && ((exe_rf_wen && exe_wb_addr == rs1_addr) ||
                                  (mem_rf_wen && mem_wb_addr == rs1_addr) ||
                                  (wb_rf_wen  && wb_wb_addr  == rs1_addr));

    assign rs2_hit = rs2_live && ((exe_rf_wen && exe_wb_addr == rs2_addr) ||
                                  (mem_rf_wen && mem_wb_addr == rs2_addr) ||
                                  (wb_rf_wen  && wb_wb_addr  == rs2_addr));

    assign data_hazard_stall = !branch_flush && (rs1_hit || rs2_hit); // flush wins

endmodule

`default_nettype wire

// File: rtl/control_decoder.sv
/*
 * RV32I control decoder
 * turns an instruction into the control fields used by execute,
 * memory and writeback; anything unknown becomes a no-op
 */
`default_nettype none

module control_decoder (
    input  wire logic [decode_pkg::xlen-1:0] inst,
    output decode_pkg::alu_fun_e             exe_fun,
    output decode_pkg::op1_sel_e             op1_sel,
    output decode_pkg::op2_sel_e             op2_sel,
    output decode_pkg::mem_fun_e             mem_fun,
    output logic                             rf_wen,
    output logic                             jmp,
    output decode_pkg::wb_sel_e              wb_sel
);
    import decode_pkg::*;

    logic [6:0] opcode;
    logic [2:0] funct3;
    logic [6:0] funct7;
    alu_fun_e   alu_f3;
    logic       legal;

    assign opcode = inst[6:0];
    assign funct3 = inst[14:12];
    assign funct7 = inst[31:25];

    // alu op from funct3, same for register and immediate forms
    always_comb begin
        case (funct3)
            f3_add:  alu_f3 = alu_add;
            f3_sll:  alu_f3 = alu_sll;
            f3_slt:  alu_f3 = alu_slt;
            f3_sltu: alu_f3 = alu_sltu;
            f3_xor:  alu_f3 = alu_xor;
            f3_sr:   alu_f3 = (funct7 == f7_alt) ? alu_sra : alu_srl;
            f3_or:   alu_f3 = alu_or;
            default: alu_f3 = alu_and;
        endcase
    end

    always_comb begin
        // start from the rs1 + imm_i alu form, most classes only tweak it
        legal   = 1'b1;
        exe_fun = alu_add;
        op1_sel = op1_rs1;
        op2_sel = op2_imm_i;
        mem_fun = mem_none;
        rf_wen  = 1'b1;
        jmp     = 1'b0;
        wb_sel  = wb_alu;
        case (opcode)
            opc_load: begin
                case (funct3)
                    f3_b:    begin mem_fun = mem_lb;  wb_sel = wb_mem_b;  end
                    f3_bu:   begin mem_fun = mem_lbu; wb_sel = wb_mem_bu; end
                    f3_h:    begin mem_fun = mem_lh;  wb_sel = wb_mem_h;  end
                    f3_hu:   begin mem_fun = mem_lhu; wb_sel = wb_mem_hu; end
                    f3_w:    begin mem_fun = mem_lw;  wb_sel = wb_mem_w;  end
                    default: legal = 1'b0;
                endcase
            end
            opc_store: begin
                op2_sel = op2_imm_s;
                rf_wen  = 1'b0;
                wb_sel  = wb_none;
                case (funct3)
                    f3_b:    mem_fun = mem_sb;
                    f3_h:    mem_fun = mem_sh;
                    f3_w:    mem_fun = mem_sw;
                    default: legal = 1'b0;
                endcase
            end
            opc_op_imm: begin
                exe_fun = alu_f3;
                if (funct3 == f3_sll && funct7 != f7_base)
                    legal = 1'b0;
                if (funct3 == f3_sr && funct7 != f7_base && funct7 != f7_alt)
                    legal = 1'b0;
            end
            opc_op: begin
                op2_sel = op2_rs2;
                exe_fun = (funct3 == f3_add && funct7 == f7_alt) ? alu_sub : alu_f3;
                if (funct7 != f7_base &&
                    !(funct7 == f7_alt && (funct3 == f3_add || funct3 == f3_sr)))
                    legal = 1'b0;
            end
            opc_branch: begin
                op2_sel = op2_rs2;
                rf_wen  = 1'b0;
                wb_sel  = wb_none;
                case (funct3)
                    f3_beq:  exe_fun = br_beq;
                    f3_bne:  exe_fun = br_bne;
                    f3_blt:  exe_fun = br_blt;
                    f3_bge:  exe_fun = br_bge;
                    f3_bltu: exe_fun = br_bltu;
                    f3_bgeu: exe_fun = br_bgeu;
                    default: legal = 1'b0;
                endcase
            end
            opc_jal: begin
                op1_sel = op1_pc;
                op2_sel = op2_imm_j;
                wb_sel  = wb_pc;    // link address
                jmp     = 1'b1;
            end
            opc_jalr: begin
                exe_fun = alu_jalr;
                wb_sel  = wb_pc;
                jmp     = 1'b1;
                legal   = (funct3 == f3_jalr);
            end
            opc_lui: begin
                op1_sel = op1_none;
                op2_sel = op2_imm_u;
            end
            opc_auipc: begin
                op1_sel = op1_pc;
                op2_sel = op2_imm_u;
            end
            default: legal = 1'b0;
        endcase
        if (!legal) begin
            exe_fun = alu_add;
            op1_sel = op1_none;
            op2_sel = op2_none;
            mem_fun = mem_none;
            rf_wen  = 1'b0;
            jmp     = 1'b0;
            wb_sel  = wb_none;
        end
    end

endmodule

`default_nettype wire

// File: rtl/operand_select.sv
/*
 * operand select
 * immediate generation and the two ALU operands, plus store data
 */
`default_nettype none

module operand_select (
    input  wire logic [decode_pkg::xlen-1:0] inst,
    input  wire logic [decode_pkg::xlen-1:0] pc,
    input  wire logic [decode_pkg::xlen-1:0] rs1_rdata,
    input  wire logic [decode_pkg::xlen-1:0] rs2_rdata,
    input  wire decode_pkg::op1_sel_e        op1_sel,
    input  wire decode_pkg::op2_sel_e        op2_sel,
    output logic      [decode_pkg::xlen-1:0] op1_data,
    output logic      [decode_pkg::xlen-1:0] op2_data,
    output logic      [decode_pkg::xlen-1:0] rs2_data,
    output logic      [decode_pkg::xlen-1:0] imm_b
);
    import decode_pkg::*;

    logic [xlen-1:0] imm_i;
    logic [xlen-1:0] imm_s;
    logic [xlen-1:0] imm_j;
    logic [xlen-1:0] imm_u;
    logic [xlen-1:0] rs1_val;

    assign imm_i = {{20{inst[31]}}, inst[31:20]};
    assign imm_s = {{20{inst[31]}}, inst[31:25], inst[11:7]};
    assign imm_b = {{19{inst[31]}}, inst[31], inst[7], inst[30:25], inst[11:8], 1'b0};
    assign imm_j = {{11{inst[31]}}, inst[31], inst[19:12], inst[20], inst[30:21], 1'b0};
    assign imm_u = {inst[31:12], 12'b0};

    // x0 reads as zero whatever the register file returns
    assign rs1_val  = (inst[19:15] == '0) ? '0 : rs1_rdata;
    assign rs2_data = (inst[24:20] == '0) ? '0 : rs2_rdata;

    always_comb begin
        case (op1_sel)
            op1_rs1: op1_data = rs1_val;
            op1_pc:  op1_data = pc;
            default: op1_data = '0;
        endcase
    end

    always_comb begin
        case (op2_sel)
            op2_rs2:   op2_data = rs2_data;
            op2_imm_i: op2_data = imm_i;
            op2_imm_s: op2_data = imm_s;
            op2_imm_j: op2_data = imm_j;
            op2_imm_u: op2_data = imm_u;
            default:   op2_data = '0;
        endcase
    end

endmodule

`default_nettype wire

// File: rtl/decode_out_reg.sv
/*
 * decode to execute pipeline register
 * loads a bubble instead of the decoded bundle while stalled
 */
`default_nettype none

module decode_out_reg (
    input  wire logic                              clk,
    input  wire logic                              arst_n,
    input  wire logic                              stall,
    input  wire logic [decode_pkg::xlen-1:0]       pc_d,
    input  wire logic [decode_pkg::xlen-1:0]       op1_d,
    input  wire logic [decode_pkg::xlen-1:0]       op2_d,
    input  wire logic [decode_pkg::xlen-1:0]       rs2_d,
    input  wire logic [decode_pkg::xlen-1:0]       imm_b_d,
    input  wire decode_pkg::alu_fun_e              exe_fun_d,
    input  wire decode_pkg::mem_fun_e              mem_fun_d,
    input  wire logic                              rf_wen_d,
    input  wire logic                              jmp_d,
    input  wire decode_pkg::wb_sel_e               wb_sel_d,
    input  wire logic [decode_pkg::reg_addr_w-1:0] wb_addr_d,
    output logic      [decode_pkg::xlen-1:0]       pc,
    output logic      [decode_pkg::xlen-1:0]       op1,
    output logic      [decode_pkg::xlen-1:0]       op2,
    output logic      [decode_pkg::xlen-1:0]       rs2,
    output logic      [decode_pkg::xlen-1:0]       imm_b,
    output decode_pkg::alu_fun_e                   exe_fun,
    output decode_pkg::mem_fun_e                   mem_fun,
    output logic                                   rf_wen,
    output logic                                   jmp,
    output decode_pkg::wb_sel_e                    wb_sel,
    output logic      [decode_pkg::reg_addr_w-1:0] wb_addr
);
    import decode_pkg::*;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin   // bubble on reset
            pc      <= regpc_nop;
            op1     <= poison_data;
            op2     <= poison_data;
            rs2     <= poison_data;
            imm_b   <= poison_data;
            exe_fun <= alu_add;
            mem_fun <= mem_none;
            rf_wen  <= 1'b0;
            jmp     <= 1'b0;
            wb_sel  <= wb_none;
            wb_addr <= '0;
        end else begin   // same bubble on a stall
            pc      <= stall ? regpc_nop : pc_d;
            op1     <= stall ? poison_data : op1_d;
            op2     <= stall ? poison_data : op2_d;
            rs2     <= stall ? poison_data : rs2_d;
            imm_b   <= stall ? poison_data : imm_b_d;
            exe_fun <= stall ? alu_add : exe_fun_d;
            mem_fun <= stall ? mem_none : mem_fun_d;
            rf_wen  <= stall ? 1'b0 : rf_wen_d;
            jmp     <= stall ? 1'b0 : jmp_d;
            wb_sel  <= stall ? wb_none : wb_sel_d;
            wb_addr <= stall ? '0 : wb_addr_d;
        end
    end

endmodule

`default_nettype wire

// File: rtl/decode_stage.sv
/*
 * RV32I decode stage
 * instruction hold, hazard check, control decode and operand
 * selection in front of the register toward execute
 */
`default_nettype none

module decode_stage (
    input  wire logic                              clk,
    input  wire logic                              arst_n,
    input  wire logic [decode_pkg::xlen-1:0]       inst_in,
    input  wire logic [decode_pkg::xlen-1:0]       pc_in,
    output logic      [decode_pkg::reg_addr_w-1:0] rs1_addr,
    output logic      [decode_pkg::reg_addr_w-1:0] rs2_addr,
    input  wire logic [decode_pkg::xlen-1:0]       rs1_rdata,
    input  wire logic [decode_pkg::xlen-1:0]       rs2_rdata,
    input  wire logic                              mem_stall,
    input  wire logic                              branch_flush,
    input  wire logic                              exe_rf_wen,
    input  wire logic [decode_pkg::reg_addr_w-1:0] exe_wb_addr,
    input  wire logic                              mem_rf_wen,
    input  wire logic [decode_pkg::reg_addr_w-1:0] mem_wb_addr,
    input  wire logic                              wb_rf_wen,
    input  wire logic [decode_pkg::reg_addr_w-1:0] wb_wb_addr,
    output logic                                   data_hazard_stall,
    output logic      [decode_pkg::xlen-1:0]       pc,
    output logic      [decode_pkg::xlen-1:0]       op1_data,
    output logic      [decode_pkg::xlen-1:0]       op2_data,
    output logic      [decode_pkg::xlen-1:0]       rs2_data,
    output logic      [decode_pkg::xlen-1:0]       imm_b,
    output decode_pkg::alu_fun_e                   exe_fun,
    output decode_pkg::mem_fun_e                   mem_fun,
    output logic                                   rf_wen,
    output decode_pkg::wb_sel_e                    wb_sel,
    output logic      [decode_pkg::reg_addr_w-1:0] wb_addr,
    output logic                                   jmp
);
    import decode_pkg::*;

    logic [xlen-1:0]       dec_inst;
    logic [xlen-1:0]       dec_pc;
    logic [xlen-1:0]       op1_d;
    logic [xlen-1:0]       op2_d;
    logic [xlen-1:0]       rs2_d;
    logic [xlen-1:0]       imm_b_d;
    logic [reg_addr_w-1:0] wb_addr_d;
    alu_fun_e              exe_fun_d;
    op1_sel_e              op1_sel;
    op2_sel_e              op2_sel;
    mem_fun_e              mem_fun_d;
    wb_sel_e               wb_sel_d;
    logic                  rf_wen_d;
    logic                  jmp_d;
    logic                  stall;

    assign rs1_addr  = dec_inst[19:15];
    assign rs2_addr  = dec_inst[24:20];
    assign wb_addr_d = dec_inst[11:7];
    assign stall     = mem_stall || data_hazard_stall;

    inst_hold_buffer u_hold (
        .clk, .arst_n, .inst_in, .pc_in, .mem_stall, .branch_flush,
        .data_hazard_stall, .inst(dec_inst), .pc(dec_pc)
    );

    hazard_detect u_hazard (
        .rs1_addr, .rs2_addr, .exe_rf_wen, .mem_rf_wen, .wb_rf_wen,
        .exe_wb_addr, .mem_wb_addr, .wb_wb_addr, .branch_flush, .data_hazard_stall
    );

    control_decoder u_dec (
        .inst(dec_inst), .exe_fun(exe_fun_d), .op1_sel, .op2_sel,
        .mem_fun(mem_fun_d), .rf_wen(rf_wen_d), .jmp(jmp_d), .wb_sel(wb_sel_d)
    );

    operand_select u_opsel (
        .inst(dec_inst), .pc(dec_pc), .rs1_rdata, .rs2_rdata, .op1_sel, .op2_sel,
        .op1_data(op1_d), .op2_data(op2_d), .rs2_data(rs2_d), .imm_b(imm_b_d)
    );

    decode_out_reg u_out (
        .clk, .arst_n, .stall,
        .pc_d(dec_pc), .op1_d, .op2_d, .rs2_d, .imm_b_d, .exe_fun_d, .mem_fun_d,
        .rf_wen_d, .jmp_d, .wb_sel_d, .wb_addr_d,
        .pc, .op1(op1_data), .op2(op2_data), .rs2(rs2_data), .imm_b, .exe_fun,
        .mem_fun, .rf_wen, .jmp, .wb_sel, .wb_addr
    );

endmodule

`default_nettype wire

// File: tb/tb_decode_model.svh
/*
 * reference model for the decode stage testbench
 * instruction encoders, register file contents and expected decode
 */
`ifndef TB_DECODE_MODEL_SVH
`define TB_DECODE_MODEL_SVH

function automatic logic [31:0] enc_r(input logic [6:0] f7, input logic [4:0] rs2,
                                      input logic [4:0] rs1, input logic [2:0] f3,
                                      input logic [4:0] rd, input logic [6:0] opc);
    return {f7, rs2, rs1, f3, rd, opc};
endfunction

function automatic logic [31:0] enc_i(input logic [11:0] imm, input logic [4:0] rs1,
                                      input logic [2:0] f3, input logic [4:0] rd,
                                      input logic [6:0] opc);
    return {imm, rs1, f3, rd, opc};
endfunction

function automatic logic [31:0] enc_s(input logic [11:0] imm, input logic [4:0] rs2,
                                      input logic [4:0] rs1, input logic [2:0] f3);
    return {imm[11:5], rs2, rs1, f3, imm[4:0], 7'h23};
endfunction

function automatic logic [31:0] enc_b(input logic [12:0] imm, input logic [4:0] rs2,
                                      input logic [4:0] rs1, input logic [2:0] f3);
    return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], 7'h63};
endfunction

function automatic logic [31:0] enc_u(input logic [19:0] imm, input logic [4:0] rd,
                                      input logic [6:0] opc);
    return {imm, rd, opc};
endfunction

function automatic logic [31:0] enc_j(input logic [20:0] imm, input logic [4:0] rd);
    return {imm[20], imm[10:1], imm[11], imm[19:12], rd, 7'h6f};
endfunction

// register r holds r copies of 0x01 in each byte
function automatic logic [31:0] reg_value(input logic [4:0] r);
    return {27'b0, r} * 32'h0101_0101;
endfunction

function automatic alu_fun_e alu_of(input logic [2:0] f3, input logic alt);
    case (f3)
        3'd0: return alu_add;
        3'd1: return alu_sll;
        3'd2: return alu_slt;
        3'd3: return alu_sltu;
        3'd4: return alu_xor;
        3'd5: return alt ? alu_sra : alu_srl;
        3'd6: return alu_or;
        default: return alu_and;
    endcase
endfunction

task automatic expected_decode(input logic [31:0] i, input logic [31:0] p,
                               output logic [31:0] o1, output logic [31:0] o2,
                               output logic [31:0] r2, output logic [31:0] ib,
                               output alu_fun_e f, output mem_fun_e m,
                               output logic w, output logic j, output wb_sel_e s);
    logic [31:0] imm_i;
    logic [31:0] imm_s;
    logic [31:0] imm_j;
    logic [31:0] imm_u;
    imm_i = {{20{i[31]}}, i[31:20]};
    imm_s = {{20{i[31]}}, i[31:25], i[11:7]};
    imm_j = {{12{i[31]}}, i[19:12], i[20], i[30:21], 1'b0};
    imm_u = {i[31:12], 12'h000};
    ib = {{20{i[31]}}, i[7], i[30:25], i[11:8], 1'b0};
    r2 = reg_value(i[24:20]);
    o1 = reg_value(i[19:15]);
    o2 = imm_i;
    f = alu_add;
    m = mem_none;
    w = 1'b1;
    j = 1'b0;
    s = wb_alu;
    case (i[6:0])
        7'h03: begin
            case (i[14:12])
                3'd0: begin m = mem_lb;  s = wb_mem_b;  end
                3'd1: begin m = mem_lh;  s = wb_mem_h;  end
                3'd2: begin m = mem_lw;  s = wb_mem_w;  end
                3'd4: begin m = mem_lbu; s = wb_mem_bu; end
                default: begin m = mem_lhu; s = wb_mem_hu; end
            endcase
        end
        7'h23: begin
            w = 1'b0;
            s = wb_none;
            o2 = imm_s;
            m = (i[14:12] == 3'd0) ? mem_sb : ((i[14:12] == 3'd1) ? mem_sh : mem_sw);
        end
        7'h13: f = alu_of(i[14:12], i[30]);
        7'h33: begin
            o2 = r2;
            f = (i[14:12] == 3'd0 && i[30]) ? alu_sub : alu_of(i[14:12], i[30]);
        end
        7'h63: begin
            w = 1'b0;
            s = wb_none;
            o2 = r2;
            case (i[14:12])
                3'd0: f = br_beq;
                3'd1: f = br_bne;
                3'd4: f = br_blt;
                3'd5: f = br_bge;
                3'd6: f = br_bltu;
                default: f = br_bgeu;
            endcase
        end
        7'h6f: begin o1 = p; o2 = imm_j; s = wb_pc; j = 1'b1; end
        7'h67: begin f = alu_jalr; s = wb_pc; j = 1'b1; end
        7'h37: begin o1 = '0; o2 = imm_u; end
        default: begin o1 = p; o2 = imm_u; end   // auipc
    endcase
endtask

`endif

// File: tb/tb_decode_stage.sv
/*
 * testbench for the RV32I decode stage
 * random instructions with hazard, memory stall and flush cases,
 * checked one cycle after acceptance against a reference model
 */
`default_nettype none

module tb_decode_stage;
    timeunit 1ns;
    timeprecision 1ps;
    import decode_pkg::*;

    `include "tb_decode_model.svh"

    localparam int n_inst = 79;

    logic clk, arst_n, mem_stall, branch_flush, data_hazard_stall;
    logic [31:0] inst_in, pc_in, rs1_rdata, rs2_rdata;
    logic [31:0] pc, op1_data, op2_data, rs2_data, imm_b;
    logic [4:0] rs1_addr, rs2_addr, wb_addr, exe_wb_addr, mem_wb_addr, wb_wb_addr;
    logic exe_rf_wen, mem_rf_wen, wb_rf_wen, rf_wen, jmp;
    alu_fun_e exe_fun;
    mem_fun_e mem_fun;
    wb_sel_e wb_sel;

    // expected bundle and the stage state as the rules describe it
    logic [31:0] e_pc, e_op1, e_op2, e_rs2, e_immb, m_saved_inst, m_saved_pc;
    logic [4:0] e_wba;
    alu_fun_e e_fun;
    mem_fun_e e_mem;
    wb_sel_e e_wb;
    logic e_wen, e_jmp, m_last_hz, taken;
    string test_name = "reset";

    decode_stage uut (.*);

    assign rs1_rdata = reg_value(rs1_addr);
    assign rs2_rdata = reg_value(rs2_addr);

    always #50 clk = ~clk;

    task automatic check_value(input string field, input logic [31:0] exp_v,
                               input logic [31:0] act_v);
        assert (act_v === exp_v) else begin
            $display("[ERROR] %s %s expected %h actual %h", test_name, field, exp_v, act_v);
            $display("Test failed");
            $fatal(1, "output mismatch");
        end
    endtask

    task automatic set_bubble();
        e_pc = regpc_nop;
        e_op1 = poison_data;
        e_op2 = poison_data;
        e_rs2 = poison_data;
        e_immb = poison_data;
        e_fun = alu_add;
        e_mem = mem_none;
        e_wen = 1'b0;
        e_jmp = 1'b0;
        e_wb = wb_none;
        e_wba = '0;
    endtask

    function automatic logic dest_hit(input logic [4:0] r);
        return r != 5'd0 && ((exe_rf_wen && exe_wb_addr == r) ||
                             (mem_rf_wen && mem_wb_addr == r) ||
                             (wb_rf_wen && wb_wb_addr == r));
    endfunction

    always @(posedge clk) begin : monitor
        logic [31:0] ei;
        logic [31:0] ep;
        logic hz;
        if (!arst_n) begin
            m_saved_inst = inst_nop;
            m_saved_pc = regpc_nop;
            m_last_hz = 1'b0;
            taken = 1'b0;
            set_bubble();
        end else begin
            ei = branch_flush ? inst_nop : ((mem_stall || m_last_hz) ? m_saved_inst : inst_in);
            ep = branch_flush ? regpc_nop : ((mem_stall || m_last_hz) ? m_saved_pc : pc_in);
            hz = !branch_flush && (dest_hit(ei[19:15]) || dest_hit(ei[24:20]));
            check_value("data_hazard_stall", 32'(hz), 32'(data_hazard_stall));
            check_value("rs1_addr", 32'(ei[19:15]), 32'(rs1_addr));
            check_value("rs2_addr", 32'(ei[24:20]), 32'(rs2_addr));
            check_value("pc", e_pc, pc);
            check_value("op1_data", e_op1, op1_data);
            check_value("op2_data", e_op2, op2_data);
            check_value("rs2_data", e_rs2, rs2_data);
            check_value("imm_b", e_immb, imm_b);
            check_value("exe_fun", 32'(e_fun), 32'(exe_fun));
            check_value("mem_fun", 32'(e_mem), 32'(mem_fun));
            check_value("rf_wen", 32'(e_wen), 32'(rf_wen));
            check_value("jmp", 32'(e_jmp), 32'(jmp));
            check_value("wb_sel", 32'(e_wb), 32'(wb_sel));
            check_value("wb_addr", 32'(e_wba), 32'(wb_addr));
            m_last_hz = hz;
            if (branch_flush) begin
                m_saved_inst = inst_nop;
                m_saved_pc = regpc_nop;
            end else if (mem_stall || hz) begin
                m_saved_inst = ei;
                m_saved_pc = ep;
            end
            if (mem_stall || hz) begin
                set_bubble();
            end else begin
                expected_decode(ei, ep, e_op1, e_op2, e_rs2, e_immb, e_fun, e_mem,
                                e_wen, e_jmp, e_wb);
                e_pc = ep;
                e_wba = ei[11:7];
            end
            taken = !(mem_stall || hz);
        end
    end

    function automatic logic [31:0] gen_inst(input int cls);
        logic [4:0] rd, rs1, rs2;
        logic [2:0] f3;
        logic [6:0] f7;
        logic coin;
        rd = 5'($urandom);
        rs1 = ($urandom % 4 == 0) ? 5'd0 : 5'($urandom);   // x0 in about a quarter
        rs2 = ($urandom % 4 == 0) ? 5'd0 : 5'($urandom);
        f3 = 3'($urandom);
        coin = 1'($urandom);
        f7 = ((f3 == 3'd0 || f3 == 3'd5) && coin) ? 7'h20 : 7'h00;
        case (cls)
            0: return enc_r(f7, rs2, rs1, f3, rd, 7'h33);
            1: begin
                if (f3 == 3'd1 || f3 == 3'd5)   // shift amounts live in the rs2 field
                    return enc_i({(f3 == 3'd5) ? f7 : 7'h00, rs2}, rs1, f3, rd, 7'h13);
                return enc_i(12'($urandom), rs1, f3, rd, 7'h13);
            end
            2: begin
                if (f3 == 3'd3 || f3 == 3'd6 || f3 == 3'd7)
                    f3 = 3'd2;
                return enc_i(12'($urandom), rs1, f3, rd, 7'h03);
            end
            3: return enc_s(12'($urandom), rs2, rs1, 3'(f3 % 3));
            4: begin
                if (f3 == 3'd2 || f3 == 3'd3)
                    f3 = 3'd6;
                return enc_b({12'($urandom), 1'b0}, rs2, rs1, f3);
            end
            5: return enc_j({20'($urandom), 1'b0}, rd);
            6: return enc_i(12'($urandom), rs1, 3'd0, rd, 7'h67);
            7: return enc_u(20'($urandom), rd, 7'h37);
            default: return enc_u(20'($urandom), rd, 7'h17);
        endcase
    endfunction

    // modes: 0 plain, 1 data hazard, 2 mem stall, 3 no-stall matches, 4 flush
    task automatic send(input logic [31:0] inst, input logic [31:0] pc_v, input int mode);
        int hz_left, ms_left, stg;
        logic [4:0] src;
        logic use_rs2;
        hz_left = (mode == 1) ? 1 + int'($urandom % 2) : 0;
        ms_left = (mode == 2) ? 1 + int'($urandom % 3) : 0;
        stg = int'($urandom % 3);
        use_rs2 = 1'($urandom);
        src = use_rs2 ? inst[24:20] : inst[19:15];
        if (src == 5'd0)    // other source field then
            src = use_rs2 ? inst[19:15] : inst[24:20];
        inst_in = inst;
        pc_in = pc_v;
        branch_flush = (mode == 4);
        mem_stall = (ms_left > 0);
        exe_wb_addr = (stg == 0) ? src : 5'($urandom);
        mem_wb_addr = (stg == 1) ? src : 5'($urandom);
        wb_wb_addr = (stg == 2) ? src : 5'($urandom);
        exe_rf_wen = (mode == 1 || mode == 4) && stg == 0;
        mem_rf_wen = (mode == 1 || mode == 4) && stg == 1;
        wb_rf_wen = (mode == 1 || mode == 4) && stg == 2;
        if (mode == 3) begin    // x0 destination written, matching one disabled
            exe_rf_wen = (stg != 0);
            if (stg != 0)
                exe_wb_addr = 5'd0;
        end
        @(negedge clk);
        while (!taken) begin
            if (hz_left > 0)
                hz_left--;
            if (hz_left == 0) begin
                exe_rf_wen = 1'b0;
                mem_rf_wen = 1'b0;
                wb_rf_wen = 1'b0;
            end
            if (ms_left > 0)
                ms_left--;
            mem_stall = (ms_left > 0);
            branch_flush = 1'b0;
            @(negedge clk);
        end
        exe_rf_wen = 1'b0;
        mem_rf_wen = 1'b0;
        wb_rf_wen = 1'b0;
        mem_stall = 1'b0;
        branch_flush = 1'b0;
    endtask

    initial begin
        #((n_inst * 4 + 20) * 100);
        $display("watchdog timeout, the stage stopped accepting instructions");
        $display("Test failed");
        $fatal(1, "timeout");
    end

    initial begin
        void'($urandom(48179));
        clk = 1'b0;
        arst_n = 1'b0;
        inst_in = inst_nop;
        pc_in = '0;
        mem_stall = 1'b0;
        branch_flush = 1'b0;
        exe_rf_wen = 1'b0;
        mem_rf_wen = 1'b0;
        wb_rf_wen = 1'b0;
        exe_wb_addr = '0;
        mem_wb_addr = '0;
        wb_wb_addr = '0;
        repeat (2) @(negedge clk);
        arst_n = 1'b1;
        test_name = "opcode_classes";
        for (int k = 0; k < 9; k++)
            send(gen_inst(k), 32'h1000 + 32'(k * 4), 0);
        test_name = "random_mix";
        for (int k = 9; k < n_inst; k++)
            send(gen_inst(int'($urandom % 9)), 32'h1000 + 32'(k * 4), int'($urandom % 5));
        @(posedge clk);
        @(negedge clk);
        $display("Test passed");
        $finish;
    end

endmodule

`default_nettype wire

// File: build.f
+incdir+tb
rtl/decode_pkg.sv
rtl/inst_hold_buffer.sv
rtl/hazard_detect.sv
rtl/control_decoder.sv
rtl/operand_select.sv
rtl/decode_out_reg.sv
rtl/decode_stage.sv
tb/tb_decode_stage.sv

// File: run_sim.sh
#!/usr/bin/env bash
# build and run the decode stage testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f build.f \
    --top-module tb_decode_stage --Mdir obj_dir -o tb_decode_stage
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

./obj_dir/tb_decode_stage
if [ $? -ne 0 ]; then
    echo "simulation failed"
    exit 1
fi
exit 0
